// ==== rtl/mpmem_pkg.sv ====
package mpmem_pkg;

  // array geometry, fixed here since the typedefs below depend on it
  localparam int addr_bits = 6;
  localparam int num_words = 64;
  localparam int word_bits = 24;

  // word address into the array
  typedef logic [addr_bits-1:0] addr_t;

  // one data word
  typedef logic [word_bits-1:0] word_t;

  // per-bit write mask, set bit means write this bit
  typedef logic [word_bits-1:0] mask_t;

  // one write port request
  // after decode, mask holds the effective mask for that port
  typedef struct packed {
    logic  en;
    addr_t addr;
    word_t data;
    mask_t mask;
  } wr_req_t;

endpackage

// ==== rtl/write_port_decode.sv ====
`timescale 1ns/1ps

module write_port_decode #(
  parameter int num_wr_ports = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  mpmem_pkg::wr_req_t wr_req [num_wr_ports],
  output mpmem_pkg::wr_req_t wr_eff [num_wr_ports],
  output logic               wr_conflict
);

  // mask left to each port after higher ports take their bits
  mpmem_pkg::mask_t eff_mask [num_wr_ports];

  // port i collided with some higher port on overlapping bits
  logic [num_wr_ports-1:0] port_overlap;
  logic                    conflict_d;

  // both enabled and aimed at the same word
  function automatic logic same_word(
    input mpmem_pkg::wr_req_t a,
    input mpmem_pkg::wr_req_t b
  );
    return a.en && b.en && (a.addr == b.addr);
  endfunction

  // two requests on one word that claim a common bit
  function automatic logic masks_overlap(
    input mpmem_pkg::wr_req_t a,
    input mpmem_pkg::wr_req_t b
  );
    return (a.mask & b.mask) != '0;
  endfunction

  // bitwise priority, higher port number wins each bit it masks
  always_comb begin
    for (int i = 0; i < num_wr_ports; i++) begin
      eff_mask[i]     = wr_req[i].mask;
      port_overlap[i] = 1'b0;
      for (int j = i + 1; j < num_wr_ports; j++) begin
        if (same_word(wr_req[i], wr_req[j])) begin
          eff_mask[i] = eff_mask[i] & ~wr_req[j].mask;
          if (masks_overlap(wr_req[i], wr_req[j])) begin
            port_overlap[i] = 1'b1;
          end
        end
      end
    end
  end

  // resolved requests to the array
  // a port left with no bits is dropped entirely
  always_comb begin
    for (int i = 0; i < num_wr_ports; i++) begin
      wr_eff[i].en   = wr_req[i].en && (eff_mask[i] != '0);
      wr_eff[i].addr = wr_req[i].addr;
      wr_eff[i].data = wr_req[i].data;
      wr_eff[i].mask = eff_mask[i];
    end
  end

  assign conflict_d = |port_overlap;

  // one-cycle pulse, the cycle after the colliding requests
  always_ff @(posedge clk) begin
    if (rst) begin
      wr_conflict <= 1'b0;
    end else begin
      wr_conflict <= conflict_d;
    end
  end

endmodule

// ==== rtl/flop_array_exec.sv ====
`timescale 1ns/1ps

module flop_array_exec #(
  parameter int num_wr_ports = 4
) (
  input  logic               clk,
  input  mpmem_pkg::wr_req_t wr_eff [num_wr_ports],
  output mpmem_pkg::word_t   mem_q  [mpmem_pkg::num_words]
);

  // next contents of every word
  mpmem_pkg::word_t mem_d [mpmem_pkg::num_words];

  // words touched by at least one port this cycle
  logic [mpmem_pkg::num_words-1:0] word_we;

  // masked bits take new data, the rest keep the stored value
  function automatic mpmem_pkg::word_t merge_bits(
    input mpmem_pkg::word_t old_word,
    input mpmem_pkg::word_t new_word,
    input mpmem_pkg::mask_t mask
  );
    return (new_word & mask) | (old_word & ~mask);
  endfunction

  // masks are disjoint after decode, so port order does not matter
  always_comb begin
    mem_d   = mem_q;
    word_we = '0;
    for (int p = 0; p < num_wr_ports; p++) begin
      if (wr_eff[p].en) begin
        mem_d[wr_eff[p].addr] = merge_bits(mem_d[wr_eff[p].addr],
                                           wr_eff[p].data,
                                           wr_eff[p].mask);
        word_we[wr_eff[p].addr] = 1'b1;
      end
    end
  end

  // flop storage, no reset
  always_ff @(posedge clk) begin
    for (int w = 0; w < mpmem_pkg::num_words; w++) begin
      if (word_we[w]) begin
        mem_q[w] <= mem_d[w];
      end
    end
  end

endmodule

// ==== rtl/read_port_result.sv ====
`timescale 1ns/1ps

module read_port_result #(
  parameter int num_rd_ports = 4,
  parameter bit flop_out     = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  logic [num_rd_ports-1:0] read,
  input  mpmem_pkg::addr_t        rd_addr [num_rd_ports],
  input  logic                    flopout_en,
  input  mpmem_pkg::word_t        mem_q   [mpmem_pkg::num_words],
  output mpmem_pkg::word_t        rd_data [num_rd_ports]
);

  // selected word per lane, zero when that lane is not reading
  mpmem_pkg::word_t rd_sel [num_rd_ports];

  // mem_q is the state before this cycle's writes
  always_comb begin
    for (int i = 0; i < num_rd_ports; i++) begin
      if (read[i]) begin
        rd_sel[i] = mem_q[rd_addr[i]];
      end else begin
        rd_sel[i] = '0;
      end
    end
  end

  if (flop_out) begin : g_flop
    mpmem_pkg::word_t        lane_q [num_rd_ports];
    logic [num_rd_ports-1:0] lane_ld;

    // a lane loads only while its strobe and the global enable are high
    assign lane_ld = read & {num_rd_ports{flopout_en}};

    always_ff @(posedge clk) begin
      if (rst) begin
        for (int i = 0; i < num_rd_ports; i++) begin
          lane_q[i] <= '0;
        end
      end else begin
        for (int i = 0; i < num_rd_ports; i++) begin
          if (lane_ld[i]) begin
            lane_q[i] <= rd_sel[i];
          end
        end
      end
    end

    always_comb begin
      for (int i = 0; i < num_rd_ports; i++) begin
        rd_data[i] = lane_q[i];
      end
    end
  end else begin : g_comb
    // same-cycle result, no enable involved
    always_comb begin
      for (int i = 0; i < num_rd_ports; i++) begin
        rd_data[i] = rd_sel[i];
      end
    end
  end

endmodule

// ==== rtl/mpmem_top.sv ====
`timescale 1ns/1ps

module mpmem_top #(
  parameter int num_wr_ports = 4,
  parameter int num_rd_ports = 4,
  parameter bit flop_out     = 1'b1
) (
  input  logic                    clk,
  input  logic                    rst,
  input  mpmem_pkg::wr_req_t      wr_req  [num_wr_ports],
  input  logic [num_rd_ports-1:0] read,
  input  mpmem_pkg::addr_t        rd_addr [num_rd_ports],
  input  logic                    flopout_en,
  output mpmem_pkg::word_t        rd_data [num_rd_ports],
  output logic                    wr_conflict
);

  // resolved writes, masks disjoint per word
  mpmem_pkg::wr_req_t wr_eff [num_wr_ports];

  // full array state
  mpmem_pkg::word_t   mem_q  [mpmem_pkg::num_words];

  write_port_decode #(
    .num_wr_ports (num_wr_ports)
  ) u_decode (
    .clk         (clk),
    .rst         (rst),
    .wr_req      (wr_req),
    .wr_eff      (wr_eff),
    .wr_conflict (wr_conflict)
  );

  flop_array_exec #(
    .num_wr_ports (num_wr_ports)
  ) u_exec (
    .clk    (clk),
    .wr_eff (wr_eff),
    .mem_q  (mem_q)
  );

  // read latency is 0 or 1 cycle depending on flop_out
  read_port_result #(
    .num_rd_ports (num_rd_ports),
    .flop_out     (flop_out)
  ) u_result (
    .clk        (clk),
    .rst        (rst),
    .read       (read),
    .rd_addr    (rd_addr),
    .flopout_en (flopout_en),
    .mem_q      (mem_q),
    .rd_data    (rd_data)
  );

endmodule

// ==== verification/mpmem_props.sv ====
`timescale 1ns/1ps

module mpmem_props #(
  parameter int num_wr_ports = 4,
  parameter int num_rd_ports = 4
) (
  input logic                    clk,
  input logic                    rst,
  input mpmem_pkg::wr_req_t      wr_req  [num_wr_ports],
  input logic [num_rd_ports-1:0] read,
  input logic                    flopout_en,
  input mpmem_pkg::word_t        rd_data [num_rd_ports],
  input logic                    wr_conflict
);

  logic overlap;
  logic lanes_zero;

  // some pair of enabled ports shares a word and a masked bit
  always_comb begin
    overlap = 1'b0;
    for (int i = 0; i < num_wr_ports; i++) begin
      for (int j = i + 1; j < num_wr_ports; j++) begin
        if (wr_req[i].en && wr_req[j].en && (wr_req[i].addr == wr_req[j].addr) &&
            ((wr_req[i].mask & wr_req[j].mask) != '0)) begin
          overlap = 1'b1;
        end
      end
    end
  end

  always_comb begin
    lanes_zero = 1'b1;
    for (int i = 0; i < num_rd_ports; i++) begin
      if (rd_data[i] != '0) begin
        lanes_zero = 1'b0;
      end
    end
  end

  conflict_has_cause: assert property (@(posedge clk) disable iff (rst)
    (wr_conflict && $past(wr_conflict)) |-> ($past(overlap) && $past(overlap, 2)))
    else $error("wr_conflict stayed high for two cycles without overlapping writes");

  reset_clears_lanes: assert property (@(posedge clk) $past(rst) |-> lanes_zero)
    else $error("rd_data not zero in the cycle after reset");

  for (genvar i = 0; i < num_rd_ports; i++) begin : g_hold
    // no load, no change
    lane_holds: assert property (@(posedge clk) disable iff (rst)
      !(read[i] && flopout_en) |=> $stable(rd_data[i]))
      else $error("rd_data lane changed while its read or flopout_en was low");
  end

endmodule

bind mpmem_top mpmem_props #(
  .num_wr_ports (num_wr_ports),
  .num_rd_ports (num_rd_ports)
) u_props (
  .clk         (clk),
  .rst         (rst),
  .wr_req      (wr_req),
  .read        (read),
  .flopout_en  (flopout_en),
  .rd_data     (rd_data),
  .wr_conflict (wr_conflict)
);

// ==== verification/mpmem_checker.sv ====
`timescale 1ns/1ps

module mpmem_checker #(
  parameter int num_wr_ports = 4,
  parameter int num_rd_ports = 4
) (
  input  logic                    clk,
  input  logic                    rst,
  input  mpmem_pkg::wr_req_t      wr_req  [num_wr_ports],
  input  logic [num_rd_ports-1:0] read,
  input  mpmem_pkg::addr_t        rd_addr [num_rd_ports],
  input  logic                    flopout_en,
  input  mpmem_pkg::word_t        rd_data [num_rd_ports],
  input  logic                    wr_conflict,
  input  logic                    exp_conflict,
  output int                      error_count,
  output int                      check_count
);

  mpmem_pkg::word_t ref_mem [mpmem_pkg::num_words];
  mpmem_pkg::word_t exp_rd  [num_rd_ports];
  logic             exp_conf;

  initial begin
    error_count = 0;
    check_count = 0;
    exp_conf    = 1'b0;
    for (int i = 0; i < num_rd_ports; i++) begin
      exp_rd[i] = '0;
    end
  end

  // inputs and outputs are both settled at the falling edge
  always @(negedge clk) begin
    logic pred;
    if (rst !== 1'b0) begin
      exp_conf = 1'b0;
      for (int i = 0; i < num_rd_ports; i++) begin
        exp_rd[i] = '0;
      end
    end else begin
      for (int i = 0; i < num_rd_ports; i++) begin
        check_count++;
        if (rd_data[i] !== exp_rd[i]) begin
          error_count++;
          $display("Fail %0t rd_data[%0d] expected %h got %h",
                   $time, i, exp_rd[i], rd_data[i]);
        end
      end
      check_count++;
      if (wr_conflict !== exp_conf) begin
        error_count++;
        $display("Fail %0t wr_conflict expected %b got %b", $time, exp_conf, wr_conflict);
      end

      // lanes load the word held before this cycle's writes
      for (int i = 0; i < num_rd_ports; i++) begin
        if (read[i] && flopout_en) begin
          exp_rd[i] = ref_mem[rd_addr[i]];
        end
      end

      pred = 1'b0;
      for (int i = 0; i < num_wr_ports; i++) begin
        for (int j = i + 1; j < num_wr_ports; j++) begin
          if (wr_req[i].en && wr_req[j].en && (wr_req[i].addr == wr_req[j].addr) &&
              ((wr_req[i].mask & wr_req[j].mask) != '0)) begin
            pred = 1'b1;
          end
        end
      end
      if (pred !== exp_conflict) begin
        error_count++;
        $display("stimulus table and reference model disagree on a collision at %0t", $time);
      end
      exp_conf = pred;

      // ascending order, so a higher port overwrites each bit it masks
      for (int p = 0; p < num_wr_ports; p++) begin
        if (wr_req[p].en) begin
          for (int b = 0; b < mpmem_pkg::word_bits; b++) begin
            if (wr_req[p].mask[b]) begin
              ref_mem[wr_req[p].addr][b] = wr_req[p].data[b];
            end
          end
        end
      end
    end
  end

endmodule

// ==== verification/mpmem_tb.sv ====
`timescale 1ns/1ps

module mpmem_tb;

  localparam int num_wr_ports   = 4;
  localparam int num_rd_ports   = 4;
  localparam int timeout_cycles = 200;

  // one cycle of stimulus with its expected collision flag
  typedef struct packed {
    mpmem_pkg::wr_req_t [num_wr_ports-1:0] wr;
    logic [num_rd_ports-1:0]               rd;
    mpmem_pkg::addr_t [num_rd_ports-1:0]   rd_addr;
    logic                                  flopout_en;
    logic                                  exp_conflict;
  } stim_row_t;

  logic                    clk;
  logic                    rst;
  mpmem_pkg::wr_req_t      wr_req  [num_wr_ports];
  logic [num_rd_ports-1:0] read;
  mpmem_pkg::addr_t        rd_addr [num_rd_ports];
  logic                    flopout_en;
  mpmem_pkg::word_t        rd_data [num_rd_ports];
  logic                    wr_conflict;

  logic        exp_conflict;
  logic        table_done;
  int          error_count;
  int          check_count;
  logic [15:0] lfsr_state;
  stim_row_t   rows [$];

  mpmem_top #(
    .num_wr_ports (num_wr_ports),
    .num_rd_ports (num_rd_ports),
    .flop_out     (1'b1)
  ) uut (
    .clk         (clk),
    .rst         (rst),
    .wr_req      (wr_req),
    .read        (read),
    .rd_addr     (rd_addr),
    .flopout_en  (flopout_en),
    .rd_data     (rd_data),
    .wr_conflict (wr_conflict)
  );

  mpmem_checker #(
    .num_wr_ports (num_wr_ports),
    .num_rd_ports (num_rd_ports)
  ) u_checker (
    .clk          (clk),
    .rst          (rst),
    .wr_req       (wr_req),
    .read         (read),
    .rd_addr      (rd_addr),
    .flopout_en   (flopout_en),
    .rd_data      (rd_data),
    .wr_conflict  (wr_conflict),
    .exp_conflict (exp_conflict),
    .error_count  (error_count),
    .check_count  (check_count)
  );

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;
  end

  // x^16 + x^14 + x^13 + x^11
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    logic fb;
    fb = s[15] ^ s[13] ^ s[12] ^ s[10];
    return {s[14:0], fb};
  endfunction

  task automatic draw_word(output mpmem_pkg::word_t w);
    for (int b = 0; b < mpmem_pkg::word_bits; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w[b] = lfsr_state[0];
    end
  endtask

  function automatic mpmem_pkg::wr_req_t wr_cmd(input int addr,
                                                input mpmem_pkg::word_t data,
                                                input mpmem_pkg::mask_t mask);
    mpmem_pkg::wr_req_t w;
    w.en   = 1'b1;
    w.addr = mpmem_pkg::addr_t'(addr);
    w.data = data;
    w.mask = mask;
    return w;
  endfunction

  function automatic stim_row_t read_row(input int a0, input int a1, input int a2, input int a3);
    stim_row_t r;
    r = '0;
    r.rd         = '1;
    r.rd_addr[0] = mpmem_pkg::addr_t'(a0);
    r.rd_addr[1] = mpmem_pkg::addr_t'(a1);
    r.rd_addr[2] = mpmem_pkg::addr_t'(a2);
    r.rd_addr[3] = mpmem_pkg::addr_t'(a3);
    r.flopout_en = 1'b1;
    return r;
  endfunction

  task automatic build_table();
    stim_row_t        r;
    mpmem_pkg::word_t w;
    // fill words 0..15 with full masks
    for (int k = 0; k < 4; k++) begin
      r = '0;
      for (int p = 0; p < num_wr_ports; p++) begin
        draw_word(w);
        r.wr[p] = wr_cmd(4 * k + p, w, '1);
      end
      rows.push_back(r);
    end
    for (int k = 0; k < 4; k++) begin
      rows.push_back(read_row(4 * k, 4 * k + 1, 4 * k + 2, 4 * k + 3));
    end
    // partial masks
    r = '0;
    r.wr[0] = wr_cmd(0, 24'hAAAAAA, 24'h0000FF);
    r.wr[1] = wr_cmd(1, 24'h555555, 24'hF0F0F0);
    rows.push_back(r);
    rows.push_back(read_row(0, 1, 2, 3));
    // two-port then three-port collisions back to back
    r = '0;
    r.wr[1] = wr_cmd(5, 24'h111111, 24'h00FFFF);
    r.wr[3] = wr_cmd(5, 24'h333333, 24'h0FFF00);
    r.exp_conflict = 1'b1;
    rows.push_back(r);
    r = '0;
    r.wr[0] = wr_cmd(6, 24'h0A0A0A, 24'hFFFFFF);
    r.wr[2] = wr_cmd(6, 24'h2B2B2B, 24'h00FFF0);
    r.wr[3] = wr_cmd(6, 24'h3C3C3C, 24'h000FFF);
    r.exp_conflict = 1'b1;
    rows.push_back(r);
    rows.push_back(read_row(5, 6, 5, 6));
    // disjoint masks on one word give no pulse
    r = '0;
    r.wr[0] = wr_cmd(7, 24'h7E0000, 24'hFF0000);
    r.wr[2] = wr_cmd(7, 24'h0000C3, 24'h0000FF);
    rows.push_back(r);
    rows.push_back(read_row(7, 7, 4, 7));
    // same-cycle read sees the old word
    r = read_row(8, 8, 9, 8);
    r.wr[2] = wr_cmd(8, 24'hABCDEF, '1);
    rows.push_back(r);
    rows.push_back(read_row(8, 8, 8, 8));
    // lane hold by flopout_en and then by one strobe
    r = read_row(10, 11, 12, 13);
    r.flopout_en = 1'b0;
    rows.push_back(r);
    r = read_row(10, 11, 12, 13);
    r.rd[2] = 1'b0;
    rows.push_back(r);
    rows.push_back(read_row(10, 11, 12, 13));
  endtask

  task automatic drive_row(input stim_row_t r);
    for (int p = 0; p < num_wr_ports; p++) begin
      wr_req[p] <= r.wr[p];
    end
    read <= r.rd;
    for (int i = 0; i < num_rd_ports; i++) begin
      rd_addr[i] <= r.rd_addr[i];
    end
    flopout_en   <= r.flopout_en;
    exp_conflict <= r.exp_conflict;
  endtask

  initial begin : stimulus
    stim_row_t idle;
    idle = '0;
    rst  = 1'b1;
    for (int p = 0; p < num_wr_ports; p++) begin
      wr_req[p] = '0;
    end
    read = '0;
    for (int i = 0; i < num_rd_ports; i++) begin
      rd_addr[i] = '0;
    end
    flopout_en   = 1'b0;
    exp_conflict = 1'b0;
    table_done   = 1'b0;
    lfsr_state   = 16'd57;
    build_table();
    repeat (5) @(posedge clk);
    rst <= 1'b0;
    foreach (rows[n]) begin
      @(posedge clk);
      drive_row(rows[n]);
    end
    @(posedge clk);
    drive_row(idle);
    table_done <= 1'b1;
  end

  initial begin : run_control
    int waited;
    waited = 0;
    while (table_done !== 1'b1 && waited < timeout_cycles) begin
      @(posedge clk);
      waited++;
    end
    if (table_done !== 1'b1) begin
      $display("timeout: the stimulus table did not finish within %0d cycles", timeout_cycles);
      $display("=== FAIL ===");
      $finish;
    end else begin
      // last loads reach rd_data one cycle later
      repeat (2) @(posedge clk);
      $display("checks: %0d  errors: %0d", check_count, error_count);
      if (error_count == 0) begin
        $display("=== PASS ===");
      end else begin
        $display("=== FAIL ===");
      end
      $finish;
    end
  end

endmodule

// ==== files.f ====
rtl/mpmem_pkg.sv
rtl/write_port_decode.sv
rtl/flop_array_exec.sv
rtl/read_port_result.sv
rtl/mpmem_top.sv
verification/mpmem_props.sv
verification/mpmem_checker.sv
verification/mpmem_tb.sv

// ==== Makefile ====
SIM       ?= verilator
SIM_FLAGS ?= --binary --timing --assert -Wno-fatal --timescale 1ns/1ps
TOP       ?= mpmem_tb
FILE_LIST ?= files.f
OBJ_DIR   ?= obj_dir
PASS_MSG  := === PASS ===

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run, fails unless the pass line is printed"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) -f $(FILE_LIST) --Mdir $(OBJ_DIR)
	@./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -Fx "$(PASS_MSG)" > /dev/null

clean:
	rm -rf $(OBJ_DIR)
